/* hw/rapid_cfg.svh */
`ifndef RAPID_CFG_SVH
`define RAPID_CFG_SVH

// Datapath and address width
`define RAPID_XLEN 32

// First fetch address out of reset
`define RAPID_RESET_PC 32'h0000_0000

// Instruction buffer entries as a power of two
`define RAPID_IBUF_DEPTH 4

// Longest wait for an instruction memory ack in cycles
`define RAPID_ACK_TIMEOUT 16

`endif

/* hw/isa_pkg.sv */
`include "rapid_cfg.svh"

package isa_pkg;

    // Plain vectors with a meaning
    typedef logic [`RAPID_XLEN-1:0] xlen_t;
    typedef logic [31:0]            instr_t;
    typedef logic [4:0]             reg_idx_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [6:0]             opcode_t;

    // Major opcodes of the supported families
    typedef enum opcode_t {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////

    function automatic opcode_t f_opcode(input instr_t instr);
        return instr[6:0];
    endfunction

    function automatic reg_idx_t f_rd(input instr_t instr);
        return instr[11:7];
    endfunction

    function automatic funct3_t f_funct3(input instr_t instr);
        return instr[14:12];
    endfunction

    function automatic reg_idx_t f_rs1(input instr_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_idx_t f_rs2(input instr_t instr);
        return instr[24:20];
    endfunction

endpackage

/* hw/pipe_pkg.sv */
`include "rapid_cfg.svh"

package pipe_pkg;

    // One-hot select of the execution block
    typedef logic [5:0] block_sel_t;

    // Bit positions inside block_sel_t
    localparam int BLK_UPPER   = 0;
    localparam int BLK_UNCOND  = 1;
    localparam int BLK_COND    = 2;
    localparam int BLK_MEM     = 3;
    localparam int BLK_ALU_IMM = 4;
    localparam int BLK_ALU_REG = 5;

    // Buffer slot index that wraps on its own
    typedef logic [$clog2(`RAPID_IBUF_DEPTH)-1:0] ibuf_ptr_t;

    // Fetch request tracking
    typedef enum logic [1:0] {
        F_REQ,
        F_WAIT,
        F_DROP
    } fetch_state_e;

endpackage

/* hw/decoder_logic.sv */
`timescale 1ns/1ps

module decoder_logic
(
    input  isa_pkg::instr_t      i_instruction,
    output pipe_pkg::block_sel_t o_block_sel,
    output logic                 o_iop,
    output isa_pkg::reg_idx_t    o_rs1,
    output isa_pkg::reg_idx_t    o_rs2,
    output isa_pkg::reg_idx_t    o_rd,
    output logic                 o_rs1_used,
    output logic                 o_rs2_used,
    output isa_pkg::funct3_t     o_fcs_opcode,
    output isa_pkg::xlen_t       o_imm,
    output logic                 o_illegal
);

    import isa_pkg::*;
    import pipe_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    //////////////////////////////////////////////////
    // Sign-extended immediate formats
    //////////////////////////////////////////////////

    assign imm_i = xlen_t'($signed(i_instruction[31:20]));
    assign imm_s = xlen_t'($signed({i_instruction[31:25], i_instruction[11:7]}));
    assign imm_b = xlen_t'($signed({i_instruction[31], i_instruction[7],
                                    i_instruction[30:25], i_instruction[11:8], 1'b0}));
    assign imm_u = xlen_t'($signed({i_instruction[31:12], 12'b0}));
    assign imm_j = xlen_t'($signed({i_instruction[31], i_instruction[19:12],
                                    i_instruction[20], i_instruction[30:21], 1'b0}));

    always_comb
    begin
        o_block_sel  = '0;
        o_iop        = 1'b0;
        o_rs1        = '0;
        o_rs2        = '0;
        o_rd         = '0;
        o_rs1_used   = 1'b0;
        o_rs2_used   = 1'b0;
        o_imm        = '0;
        o_illegal    = 1'b0;
        // Operation inside the block uses one field for all
        o_fcs_opcode = f_funct3(i_instruction);

        case (f_opcode(i_instruction))
            OP_LUI, OP_AUIPC:
            begin
                o_block_sel[BLK_UPPER] = 1'b1;
                // High for LUI, low for AUIPC
                o_iop = i_instruction[5];
                o_rd  = f_rd(i_instruction);
                o_imm = imm_u;
            end
            OP_JAL:
            begin
                o_block_sel[BLK_UNCOND] = 1'b1;
                // Separates JAL from JALR
                o_iop = i_instruction[3];
                o_rd  = f_rd(i_instruction);
                o_imm = imm_j;
            end
            OP_JALR:
            begin
                o_block_sel[BLK_UNCOND] = 1'b1;
                o_iop      = i_instruction[3];
                o_rd       = f_rd(i_instruction);
                // Target base comes from rs1
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_imm      = imm_i;
            end
            OP_BRANCH:
            begin
                o_block_sel[BLK_COND] = 1'b1;
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_rs2      = f_rs2(i_instruction);
                o_rs2_used = 1'b1;
                o_imm      = imm_b;
            end
            OP_LOAD:
            begin
                // Load is the non-inverted memory op
                o_block_sel[BLK_MEM] = 1'b1;
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_rd       = f_rd(i_instruction);
                o_imm      = imm_i;
            end
            OP_STORE:
            begin
                o_block_sel[BLK_MEM] = 1'b1;
                o_iop      = i_instruction[5];
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_rs2      = f_rs2(i_instruction);
                o_rs2_used = 1'b1;
                o_imm      = imm_s;
            end
            OP_IMM:
            begin
                o_block_sel[BLK_ALU_IMM] = 1'b1;
                // SRAI against SRLI
                o_iop      = i_instruction[30];
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_rd       = f_rd(i_instruction);
                o_imm      = imm_i;
            end
            OP_REG:
            begin
                o_block_sel[BLK_ALU_REG] = 1'b1;
                // SUB and SRA
                o_iop      = i_instruction[30];
                o_rs1      = f_rs1(i_instruction);
                o_rs1_used = 1'b1;
                o_rs2      = f_rs2(i_instruction);
                o_rs2_used = 1'b1;
                o_rd       = f_rd(i_instruction);
            end
            default:
                o_illegal = 1'b1;
        endcase
    end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`include "rapid_cfg.svh"

module fetch_unit
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_imem_ack,
    input  isa_pkg::instr_t i_imem_rdata,
    input  logic            i_buf_full,
    input  logic            i_redirect,
    input  isa_pkg::xlen_t  i_redirect_pc,
    output logic            o_imem_req,
    output isa_pkg::xlen_t  o_imem_addr,
    output logic            o_buf_wr,
    output isa_pkg::xlen_t  o_buf_wr_pc,
    output isa_pkg::instr_t o_buf_wr_instr
);

    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_state_e state;
    fetch_state_e state_next;
    xlen_t        pc_q;
    xlen_t        pc_next;
    xlen_t        addr_q;
    logic         accept;
    logic         slot_free;
    logic         launch;

    // Ack of a live request not cancelled this cycle
    assign accept    = (state == F_WAIT) && i_imem_ack && !i_redirect;
    // Nothing outstanding after this edge
    assign slot_free = (state == F_REQ) || i_imem_ack;
    // Redirect flushes the buffer and frees room
    assign launch    = slot_free && (!i_buf_full || i_redirect);

    //////////////////////////////////////////////////
    // Next PC and state
    //////////////////////////////////////////////////

    always_comb
    begin
        if (i_redirect)
            pc_next = i_redirect_pc;
        else if (accept)
            pc_next = pc_q + xlen_t'(4);
        else
            pc_next = pc_q;
    end

    always_comb
    begin
        if (slot_free)
            state_next = launch ? F_WAIT : F_REQ;
        // Still waiting but the data is now stale
        else if (i_redirect)
            state_next = F_DROP;
        else
            state_next = state;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state <= F_REQ;
            pc_q  <= `RAPID_RESET_PC;
        end
        else
        begin
            state <= state_next;
            pc_q  <= pc_next;
        end
    end

    // Address of the outstanding request
    always_ff @(posedge i_clk)
    begin
        if (launch)
            addr_q <= pc_next;
    end

    // Request level covers both waiting states
    assign o_imem_req     = (state != F_REQ);
    assign o_imem_addr    = addr_q;
    assign o_buf_wr       = accept;
    assign o_buf_wr_pc    = addr_q;
    assign o_buf_wr_instr = i_imem_rdata;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Request holds with a stable address until acked
    a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_imem_req && !i_imem_ack |=> o_imem_req && $stable(o_imem_addr))
        else $error("o_imem_addr moved while waiting: %h", o_imem_addr);

    // Memory answers in bounded time
    a_ack_timeout: assert property (@(posedge i_clk) disable iff (i_rst)
        o_imem_req |-> ##[0:`RAPID_ACK_TIMEOUT] i_imem_ack)
        else $error("i_imem_ack missing, o_imem_addr %h", o_imem_addr);

endmodule

/* hw/instr_buffer.sv */
`timescale 1ns/1ps
`include "rapid_cfg.svh"

module instr_buffer
(
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_wr,
    input  isa_pkg::xlen_t  i_wr_pc,
    input  isa_pkg::instr_t i_wr_instr,
    input  logic            i_pop,
    input  logic            i_flush,
    output logic            o_empty,
    output logic            o_full,
    output isa_pkg::xlen_t  o_head_pc,
    output isa_pkg::instr_t o_head_instr
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int DEPTH = `RAPID_IBUF_DEPTH;

    // Occupancy needs one bit more than a pointer
    typedef logic [$bits(ibuf_ptr_t):0] count_t;

    // One slot stays reserved for the request in flight
    localparam count_t FULL_MARK = count_t'(DEPTH - 1);
    localparam count_t TRUE_FULL = count_t'(DEPTH);

    xlen_t     pc_mem    [DEPTH];
    instr_t    instr_mem [DEPTH];
    ibuf_ptr_t wr_ptr;
    ibuf_ptr_t rd_ptr;
    count_t    count;
    logic      do_wr;
    logic      do_pop;

    // Flush wins over both ends
    assign do_wr  = i_wr && !i_flush;
    assign do_pop = i_pop && !i_flush;

    always_ff @(posedge i_clk)
    begin
        if (do_wr)
        begin
            pc_mem[wr_ptr]    <= i_wr_pc;
            instr_mem[wr_ptr] <= i_wr_instr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Write and pop together leave the count alone
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_empty      = (count == '0);
    assign o_full       = (count >= FULL_MARK);
    assign o_head_pc    = pc_mem[rd_ptr];
    assign o_head_instr = instr_mem[rd_ptr];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Decode only pops a visible entry
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
        i_pop |-> !o_empty)
        else $error("i_pop with empty buffer, count %h", count);

    // Fetch must respect the reserved slot
    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
        do_wr |-> count != TRUE_FULL)
        else $error("i_wr into full buffer, i_wr_pc %h", i_wr_pc);

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_buf_empty,
    input  isa_pkg::xlen_t       i_head_pc,
    input  isa_pkg::instr_t      i_head_instr,
    input  logic                 i_ex_stall,
    input  logic                 i_redirect,
    output logic                 o_pop,
    output logic                 o_dec_valid,
    output isa_pkg::xlen_t       o_dec_pc,
    output pipe_pkg::block_sel_t o_dec_block_sel,
    output logic                 o_dec_iop,
    output isa_pkg::reg_idx_t    o_dec_rs1,
    output isa_pkg::reg_idx_t    o_dec_rs2,
    output isa_pkg::reg_idx_t    o_dec_rd,
    output logic                 o_dec_rs1_used,
    output logic                 o_dec_rs2_used,
    output isa_pkg::funct3_t     o_dec_fcs_opcode,
    output isa_pkg::xlen_t       o_dec_imm,
    output logic                 o_dec_illegal
);

    import isa_pkg::*;
    import pipe_pkg::*;

    block_sel_t block_sel;
    logic       iop;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       rs1_used;
    logic       rs2_used;
    funct3_t    fcs_opcode;
    xlen_t      imm;
    logic       illegal;

    decoder_logic u_decoder
    (
        .i_instruction (i_head_instr),
        .o_block_sel   (block_sel),
        .o_iop         (iop),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd),
        .o_rs1_used    (rs1_used),
        .o_rs2_used    (rs2_used),
        .o_fcs_opcode  (fcs_opcode),
        .o_imm         (imm),
        .o_illegal     (illegal)
    );

    // Head leaves when execution takes it and no redirect discards it
    assign o_pop = !i_buf_empty && !i_ex_stall && !i_redirect;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_redirect)
            o_dec_valid <= 1'b0;
        else if (!i_ex_stall)
            o_dec_valid <= o_pop;
    end

    // Decoded payload loads only on pop
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            o_dec_pc         <= i_head_pc;
            o_dec_block_sel  <= block_sel;
            o_dec_iop        <= iop;
            o_dec_rs1        <= rs1;
            o_dec_rs2        <= rs2;
            o_dec_rd         <= rd;
            o_dec_rs1_used   <= rs1_used;
            o_dec_rs2_used   <= rs2_used;
            o_dec_fcs_opcode <= fcs_opcode;
            o_dec_imm        <= imm;
            o_dec_illegal    <= illegal;
        end
    end

    // Stalled output is frozen for execution
    a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_dec_valid && i_ex_stall && !i_redirect |=>
            $stable({o_dec_valid, o_dec_pc, o_dec_block_sel, o_dec_iop, o_dec_rs1,
                     o_dec_rs2, o_dec_rd, o_dec_rs1_used, o_dec_rs2_used,
                     o_dec_fcs_opcode, o_dec_imm, o_dec_illegal}))
        else $error("decode output moved under stall, o_dec_pc %h", o_dec_pc);

endmodule

/* hw/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    output logic                 o_imem_req,
    output isa_pkg::xlen_t       o_imem_addr,
    input  logic                 i_imem_ack,
    input  isa_pkg::instr_t      i_imem_rdata,
    input  logic                 i_ex_stall,
    input  logic                 i_redirect,
    input  isa_pkg::xlen_t       i_redirect_pc,
    output logic                 o_dec_valid,
    output isa_pkg::xlen_t       o_dec_pc,
    output pipe_pkg::block_sel_t o_dec_block_sel,
    output logic                 o_dec_iop,
    output isa_pkg::reg_idx_t    o_dec_rs1,
    output isa_pkg::reg_idx_t    o_dec_rs2,
    output isa_pkg::reg_idx_t    o_dec_rd,
    output logic                 o_dec_rs1_used,
    output logic                 o_dec_rs2_used,
    output isa_pkg::funct3_t     o_dec_fcs_opcode,
    output isa_pkg::xlen_t       o_dec_imm,
    output logic                 o_dec_illegal
);

    import isa_pkg::*;

    logic   buf_wr;
    xlen_t  buf_wr_pc;
    instr_t buf_wr_instr;
    logic   buf_full;
    logic   buf_empty;
    logic   buf_pop;
    xlen_t  head_pc;
    instr_t head_instr;

    //////////////////////////////////////////////////
    // Fetch, buffer, decode
    //////////////////////////////////////////////////

    fetch_unit u_fetch
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_imem_ack     (i_imem_ack),
        .i_imem_rdata   (i_imem_rdata),
        .i_buf_full     (buf_full),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .o_buf_wr       (buf_wr),
        .o_buf_wr_pc    (buf_wr_pc),
        .o_buf_wr_instr (buf_wr_instr)
    );

    // Redirect empties the queue
    instr_buffer u_ibuf
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wr         (buf_wr),
        .i_wr_pc      (buf_wr_pc),
        .i_wr_instr   (buf_wr_instr),
        .i_pop        (buf_pop),
        .i_flush      (i_redirect),
        .o_empty      (buf_empty),
        .o_full       (buf_full),
        .o_head_pc    (head_pc),
        .o_head_instr (head_instr)
    );

    decode_stage u_decode
    (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_buf_empty      (buf_empty),
        .i_head_pc        (head_pc),
        .i_head_instr     (head_instr),
        .i_ex_stall       (i_ex_stall),
        .i_redirect       (i_redirect),
        .o_pop            (buf_pop),
        .o_dec_valid      (o_dec_valid),
        .o_dec_pc         (o_dec_pc),
        .o_dec_block_sel  (o_dec_block_sel),
        .o_dec_iop        (o_dec_iop),
        .o_dec_rs1        (o_dec_rs1),
        .o_dec_rs2        (o_dec_rs2),
        .o_dec_rd         (o_dec_rd),
        .o_dec_rs1_used   (o_dec_rs1_used),
        .o_dec_rs2_used   (o_dec_rs2_used),
        .o_dec_fcs_opcode (o_dec_fcs_opcode),
        .o_dec_imm        (o_dec_imm),
        .o_dec_illegal    (o_dec_illegal)
    );

endmodule

/* sim/tb_frontend.sv */
`timescale 1ns/1ps
`include "rapid_cfg.svh"

module tb_frontend;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_DECODES = 400;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       o_imem_req;
    xlen_t      o_imem_addr;
    logic       i_imem_ack;
    instr_t     i_imem_rdata;
    logic       i_ex_stall;
    logic       i_redirect;
    xlen_t      i_redirect_pc;
    logic       o_dec_valid;
    xlen_t      o_dec_pc;
    block_sel_t o_dec_block_sel;
    logic       o_dec_iop;
    reg_idx_t   o_dec_rs1;
    reg_idx_t   o_dec_rs2;
    reg_idx_t   o_dec_rd;
    logic       o_dec_rs1_used;
    logic       o_dec_rs2_used;
    funct3_t    o_dec_fcs_opcode;
    xlen_t      o_dec_imm;
    logic       o_dec_illegal;

    // Program image indexed by address bits [5:2]
    instr_t      prog [16];
    integer      seed = 32'h17ea62ec;
    logic [31:0] rnd;
    logic [1:0]  ack_delay;
    int          errors = 0;
    int          decodes = 0;
    int          redirects = 0;

    // Decode scoreboard state
    logic        redirect_pending;
    xlen_t       redirect_target;
    xlen_t       last_pc;
    logic        prev_hold;
    logic [92:0] prev_bundle;
    logic [59:0] exp_fields;
    logic [59:0] dec_fields;
    logic [92:0] dec_bundle;

    assign dec_fields = {o_dec_block_sel, o_dec_iop, o_dec_rs1, o_dec_rs2, o_dec_rd,
                         o_dec_rs1_used, o_dec_rs2_used, o_dec_fcs_opcode, o_dec_imm,
                         o_dec_illegal};
    assign dec_bundle = {o_dec_valid, o_dec_pc, dec_fields};

    frontend_top DUT
    (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .o_imem_req       (o_imem_req),
        .o_imem_addr      (o_imem_addr),
        .i_imem_ack       (i_imem_ack),
        .i_imem_rdata     (i_imem_rdata),
        .i_ex_stall       (i_ex_stall),
        .i_redirect       (i_redirect),
        .i_redirect_pc    (i_redirect_pc),
        .o_dec_valid      (o_dec_valid),
        .o_dec_pc         (o_dec_pc),
        .o_dec_block_sel  (o_dec_block_sel),
        .o_dec_iop        (o_dec_iop),
        .o_dec_rs1        (o_dec_rs1),
        .o_dec_rs2        (o_dec_rs2),
        .o_dec_rd         (o_dec_rd),
        .o_dec_rs1_used   (o_dec_rs1_used),
        .o_dec_rs2_used   (o_dec_rs2_used),
        .o_dec_fcs_opcode (o_dec_fcs_opcode),
        .o_dec_imm        (o_dec_imm),
        .o_dec_illegal    (o_dec_illegal)
    );

    //////////////////////////////////////////////////
    // Expected decode from the RV32I encoding
    //////////////////////////////////////////////////

    function automatic logic [59:0] expect_decode(input logic [31:0] w);
        logic [5:0]  blk;
        logic        iop;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        use1;
        logic        use2;
        logic [31:0] imm;
        logic        ill;
        blk  = '0;
        iop  = 1'b0;
        rs1  = '0;
        rs2  = '0;
        rd   = '0;
        use1 = 1'b0;
        use2 = 1'b0;
        imm  = '0;
        ill  = 1'b0;
        case (w[6:0])
            // LUI and AUIPC
            7'b0110111, 7'b0010111:
            begin
                blk[0] = 1'b1;
                iop    = w[5];
                rd     = w[11:7];
                imm    = {w[31:12], 12'b0};
            end
            // JAL
            7'b1101111:
            begin
                blk[1] = 1'b1;
                iop    = w[3];
                rd     = w[11:7];
                imm    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            // JALR
            7'b1100111:
            begin
                blk[1] = 1'b1;
                iop    = w[3];
                rd     = w[11:7];
                rs1    = w[19:15];
                use1   = 1'b1;
                imm    = {{20{w[31]}}, w[31:20]};
            end
            // Conditional branch
            7'b1100011:
            begin
                blk[2] = 1'b1;
                rs1    = w[19:15];
                rs2    = w[24:20];
                use1   = 1'b1;
                use2   = 1'b1;
                imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            // Load
            7'b0000011:
            begin
                blk[3] = 1'b1;
                rs1    = w[19:15];
                use1   = 1'b1;
                rd     = w[11:7];
                imm    = {{20{w[31]}}, w[31:20]};
            end
            // Store
            7'b0100011:
            begin
                blk[3] = 1'b1;
                iop    = w[5];
                rs1    = w[19:15];
                rs2    = w[24:20];
                use1   = 1'b1;
                use2   = 1'b1;
                imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            // ALU immediate
            7'b0010011:
            begin
                blk[4] = 1'b1;
                iop    = w[30];
                rs1    = w[19:15];
                use1   = 1'b1;
                rd     = w[11:7];
                imm    = {{20{w[31]}}, w[31:20]};
            end
            // ALU register has no immediate
            7'b0110011:
            begin
                blk[5] = 1'b1;
                iop    = w[30];
                rs1    = w[19:15];
                rs2    = w[24:20];
                use1   = 1'b1;
                use2   = 1'b1;
                rd     = w[11:7];
            end
            default:
                ill = 1'b1;
        endcase
        return {blk, iop, rs1, rs2, rd, use1, use2, w[14:12], imm, ill};
    endfunction

    //////////////////////////////////////////////////
    // Clock, memory model, stall and redirect
    //////////////////////////////////////////////////

    initial
    begin
        forever #4 i_clk = ~i_clk;
    end

    // Single random draw per cycle keeps the sequence fixed
    always @(posedge i_clk)
    begin
        rnd = $random(seed);
        if (i_rst)
        begin
            i_imem_ack <= 1'b0;
            i_ex_stall <= 1'b0;
            i_redirect <= 1'b0;
            ack_delay  <= rnd[1:0];
        end
        else
        begin
            // One ack pulse per request followed by a fresh delay
            if (i_imem_ack)
            begin
                i_imem_ack <= 1'b0;
                ack_delay  <= rnd[1:0];
            end
            else if (o_imem_req)
            begin
                if (ack_delay == 2'd0)
                begin
                    i_imem_ack   <= 1'b1;
                    i_imem_rdata <= prog[o_imem_addr[5:2]];
                end
                else
                    ack_delay <= ack_delay - 2'd1;
            end
            // Stall about 3 cycles in 8
            i_ex_stall    <= (rnd[4:2] < 3'd3);
            // Rare single-cycle redirect
            i_redirect    <= !i_redirect && (rnd[9:5] == 5'd0);
            i_redirect_pc <= {24'b0, rnd[15:10], 2'b00};
        end
    end

    //////////////////////////////////////////////////
    // Checks sampled mid-cycle
    //////////////////////////////////////////////////

    always @(negedge i_clk)
    begin
        if (i_rst)
        begin
            assert (o_dec_valid === 1'b0 && o_imem_req === 1'b0)
            else
            begin
                errors++;
                $display("error o_dec_valid %h o_imem_req %h under reset",
                         o_dec_valid, o_imem_req);
            end
            // First decode must come from the reset PC
            redirect_pending = 1'b1;
            redirect_target  = `RAPID_RESET_PC;
            prev_hold        = 1'b0;
        end
        else
        begin
            if (prev_hold)
            begin
                assert (dec_bundle === prev_bundle)
                else
                begin
                    errors++;
                    $display("error dec_bundle under stall got %h expected %h",
                             dec_bundle, prev_bundle);
                end
            end
            else if (o_dec_valid)
            begin
                decodes++;
                exp_fields = expect_decode(prog[o_dec_pc[5:2]]);
                assert (dec_fields === exp_fields)
                else
                begin
                    errors++;
                    $display("error dec_fields at o_dec_pc %h got %h expected %h",
                             o_dec_pc, dec_fields, exp_fields);
                end
                if (redirect_pending)
                begin
                    assert (o_dec_pc === redirect_target)
                    else
                    begin
                        errors++;
                        $display("error o_dec_pc after redirect got %h expected %h",
                                 o_dec_pc, redirect_target);
                    end
                end
                else
                begin
                    assert (o_dec_pc === last_pc + 32'd4)
                    else
                    begin
                        errors++;
                        $display("error o_dec_pc in sequence got %h expected %h",
                                 o_dec_pc, last_pc + 32'd4);
                    end
                end
                last_pc          = o_dec_pc;
                redirect_pending = 1'b0;
            end
            // Redirect lands at the coming edge
            if (i_redirect)
            begin
                redirects++;
                redirect_pending = 1'b1;
                redirect_target  = i_redirect_pc;
            end
            prev_hold = o_dec_valid && i_ex_stall && !i_redirect;
        end
        prev_bundle = dec_bundle;
    end

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    task automatic check_first_request;
        int cycles;
        cycles = 0;
        while (!o_imem_req && cycles < 20)
        begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_imem_req)
        begin
            errors++;
            $display("timeout: no instruction memory request after reset");
        end
        else
        begin
            assert (o_imem_addr === `RAPID_RESET_PC)
            else
            begin
                errors++;
                $display("error o_imem_addr first request got %h expected %h",
                         o_imem_addr, `RAPID_RESET_PC);
            end
        end
    endtask

    task automatic wait_for_decodes(input int target);
        int cycles;
        cycles = 0;
        while (decodes < target && cycles < target * 40)
        begin
            @(posedge i_clk);
            cycles++;
        end
        if (decodes < target)
        begin
            errors++;
            $display("timeout: only %0d of %0d decodes seen", decodes, target);
        end
    endtask

    initial
    begin
        i_rst         = 1'b1;
        i_imem_ack    = 1'b0;
        i_imem_rdata  = '0;
        i_ex_stall    = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        // Every family at least once plus ECALL in slot 11
        prog[0]  = 32'h123450b7;
        prog[1]  = 32'hfffff117;
        prog[2]  = 32'hff9ff1ef;
        prog[3]  = 32'h00c28267;
        prog[4]  = 32'hfe7318e3;
        prog[5]  = 32'hffc4a403;
        prog[6]  = 32'h00a5a423;
        prog[7]  = 32'hfff68613;
        prog[8]  = 32'h4037d713;
        prog[9]  = 32'h01288833;
        prog[10] = 32'h415a09b3;
        prog[11] = 32'h00000073;
        prog[12] = 32'hfe112e23;
        prog[13] = 32'h0ff1e193;
        prog[14] = 32'h0020c463;
        prog[15] = 32'h00010003;

        repeat (5) @(posedge i_clk);
        i_rst <= 1'b0;
        check_first_request();
        wait_for_decodes(NUM_DECODES);

        $display("decodes %0d redirects %0d errors %0d", decodes, redirects, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/decoder_logic.sv
hw/fetch_unit.sv
hw/instr_buffer.sv
hw/decode_stage.sv
hw/frontend_top.sv
sim/tb_frontend.sv
